//--- Makefile
# Verilator build and run of the reorder buffer backend testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_rob_backend
RTL_TOP    ?= rob_backend_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= TESTBENCH PASSED

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$($(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+src
src/lc3b_pkg.sv
src/alu_unit.sv
src/shift_unit.sv
src/cdb_arbiter.sv
src/arch_regfile.sv
src/reorder_buffer_data.sv
src/rob_backend_top.sv
tests/tb_clk_gen.sv
tests/tb_rob_backend.sv

//--- src/alu_unit.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module alu_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      issue,
	input  logic [`ROB_TAG_WIDTH-1:0] issue_tag,
	input  lc3b_pkg::lc3b_opcode      op,
	input  logic [`DATA_WIDTH-1:0]    a,
	input  logic [`DATA_WIDTH-1:0]    b,
	input  logic                      grant,
	output logic                      busy,
	output logic                      req,
	output logic [`ROB_TAG_WIDTH-1:0] req_tag,
	output logic [`DATA_WIDTH-1:0]    req_value
);
	import lc3b_pkg::*;

	logic                   pending; // Result computed and waiting for the CDB
	logic [`DATA_WIDTH-1:0] result;

	always_comb
	begin
		case (op)
			op_add: result = a + b;
			op_and: result = a & b;
			op_not: result = ~a;
			default: result = a; // Not issued here
		endcase
	end

	// One stage, so the request goes up right after the issue edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else if (flush)
			pending <= 1'b0;
		else if (issue)
			pending <= 1'b1;
		else if (grant)
			pending <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			req_tag <= issue_tag;
			req_value <= result;
		end
	end

	assign busy = pending; // Stays high through the granted cycle
	assign req = pending;

	// The buffer must hold ALU dispatch back while a result is unclaimed
	a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !issue)
		else $error("ALU issued while busy");

endmodule

//--- src/arch_regfile.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module arch_regfile (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      retire_valid,
	input  lc3b_pkg::lc3b_opcode      retire_op,
	input  lc3b_pkg::lc3b_reg         retire_dest,
	input  logic [`DATA_WIDTH-1:0]    retire_value,
	input  logic [`REG_ADDR_WIDTH-1:0] rf_addr,
	output logic [`DATA_WIDTH-1:0]    rf_data
);
	import lc3b_pkg::*;

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic                   write_en;

	// Stores, branches and traps retire without touching a register
	assign write_en = retire_valid
		&& (retire_op inside {op_add, op_and, op_not, op_shf, op_lea, op_ldb, op_ldr, op_ldi});

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (write_en)
			regs[retire_dest] <= retire_value;
	end

	assign rf_data = regs[rf_addr]; // Test read port

endmodule

//--- src/cdb_arbiter.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module cdb_arbiter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      alu_req,
	input  logic [`ROB_TAG_WIDTH-1:0] alu_tag,
	input  logic [`DATA_WIDTH-1:0]    alu_value,
	input  logic                      shf_req,
	input  logic [`ROB_TAG_WIDTH-1:0] shf_tag,
	input  logic [`DATA_WIDTH-1:0]    shf_value,
	output logic                      alu_grant,
	output logic                      shf_grant,
	output logic                      cdb_valid,
	output logic [`ROB_TAG_WIDTH-1:0] cdb_tag,
	output logic [`DATA_WIDTH-1:0]    cdb_value
);

	logic last_shf; // Set when the shifter won the last granted cycle

	// On contention the client that did not win last time gets the bus
	assign alu_grant = alu_req && (!shf_req || last_shf);
	assign shf_grant = shf_req && (!alu_req || !last_shf);

	assign cdb_valid = alu_req || shf_req; // Someone always wins when anyone asks
	assign cdb_tag = shf_grant ? shf_tag : alu_tag;
	assign cdb_value = shf_grant ? shf_value : alu_value;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			last_shf <= 1'b0;
		else if (cdb_valid)
			last_shf <= shf_grant;
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({alu_grant, shf_grant}) && (!alu_grant || alu_req) && (!shf_grant || shf_req))
		else $error("CDB grant is not one-hot to a requester");

endmodule

//--- src/lc3b_pkg.sv
`include "rob_macros.svh"

package lc3b_pkg;

	// Standard LC-3b opcode encodings from instruction bits 15:12
	typedef enum logic [3:0] {
		op_br   = 4'd0,  // Conditional branch
		op_add  = 4'd1,  // Goes to the ALU
		op_ldb  = 4'd2,
		op_stb  = 4'd3,
		op_jsr  = 4'd4,
		op_and  = 4'd5,  // Goes to the ALU
		op_ldr  = 4'd6,
		op_str  = 4'd7,
		op_rti  = 4'd8,
		op_not  = 4'd9,  // Goes to the ALU
		op_ldi  = 4'd10,
		op_sti  = 4'd11,
		op_jmp  = 4'd12,
		op_shf  = 4'd13, // Goes to the shifter
		op_lea  = 4'd14,
		op_trap = 4'd15
	} lc3b_opcode;

	// Architectural register index R0 to R7
	typedef logic [`REG_ADDR_WIDTH-1:0] lc3b_reg;

	// Control bits of SHF inside operand b, the low four bits hold the amount
	localparam int shf_dir_bit = 4;   // 0 shifts left, 1 shifts right
	localparam int shf_arith_bit = 5; // Right shifts copy the sign bit when set

endpackage

//--- src/reorder_buffer_data.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module reorder_buffer_data #(
	parameter int data_width = `DATA_WIDTH,
	parameter int tag_width = `ROB_TAG_WIDTH
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush,
	input  logic                  dispatch,
	input  lc3b_pkg::lc3b_opcode  dispatch_op,
	input  lc3b_pkg::lc3b_reg     dispatch_dest,
	input  logic [data_width-1:0] dispatch_a,
	input  logic                  alu_busy,
	input  logic                  shf_busy,
	input  logic                  cdb_valid,
	input  logic [tag_width-1:0]  cdb_tag,
	input  logic [data_width-1:0] cdb_value,
	input  logic [tag_width-1:0]  lookup_tag1,
	input  logic [tag_width-1:0]  lookup_tag2,
	output logic                  dispatch_ready,
	output logic [tag_width-1:0]  dispatch_tag,
	output logic                  alu_issue,
	output logic                  shf_issue,
	output logic [data_width-1:0] lookup_value1,
	output logic                  lookup_valid1,
	output logic [data_width-1:0] lookup_value2,
	output logic                  lookup_valid2,
	output logic                  retire_valid,
	output lc3b_pkg::lc3b_opcode  retire_op,
	output lc3b_pkg::lc3b_reg     retire_dest,
	output logic [data_width-1:0] retire_value,
	output logic                  empty,
	output logic                  full
);
	import lc3b_pkg::*;

	localparam int depth = 2 ** tag_width;

	logic [tag_width-1:0]  head; // Oldest entry, next to retire
	logic [tag_width-1:0]  tail; // Next free slot, handed out as the tag
	logic [tag_width:0]    count; // One bit wider than a tag so full is visible
	logic [depth-1:0]      valid;
	lc3b_opcode            op_mem [depth];
	lc3b_reg               dest_mem [depth];
	logic [data_width-1:0] value_mem [depth];

	logic                 alu_bound;
	logic                 shf_bound;
	logic                 accept;
	logic [tag_width-1:0] cdb_offset; // Distance of the CDB tag from the head

	assign empty = (count == '0);
	assign full = (count == (tag_width + 1)'(depth));

	// Route by opcode, anything else has its value at dispatch
	assign alu_bound = dispatch_op inside {op_add, op_and, op_not};
	assign shf_bound = (dispatch_op == op_shf);

	// A unit still holding a result cannot take another instruction
	assign dispatch_ready = !full && !flush && !(alu_bound && alu_busy)
		&& !(shf_bound && shf_busy);
	assign accept = dispatch && dispatch_ready;
	assign alu_issue = accept && alu_bound;
	assign shf_issue = accept && shf_bound;
	assign dispatch_tag = tail;

	// The head leaves as soon as its value is present, nothing retires during flush
	assign retire_valid = !empty && valid[head] && !flush;
	assign retire_op = op_mem[head];
	assign retire_dest = dest_mem[head];
	assign retire_value = value_mem[head];

	// Forwarding reads by tag
	assign lookup_value1 = value_mem[lookup_tag1];
	assign lookup_valid1 = valid[lookup_tag1];
	assign lookup_value2 = value_mem[lookup_tag2];
	assign lookup_valid2 = valid[lookup_tag2];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid <= '0;
		end
		else if (flush)
		begin
			head <= '0; // New work starts again at tag 0
			tail <= '0;
			count <= '0;
			valid <= '0;
		end
		else
		begin
			if (accept)
			begin
				valid[tail] <= !(alu_bound || shf_bound);
				tail <= tail + 1'b1;
			end
			if (cdb_valid)
				valid[cdb_tag] <= 1'b1; // Write-back at the tag, as any slot may finish first
			if (retire_valid)
			begin
				valid[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({accept, retire_valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither keep the fill level
			endcase
		end
	end

	// Entry payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_mem[tail] <= dispatch_op;
			dest_mem[tail] <= dispatch_dest;
			value_mem[tail] <= dispatch_a; // Unit results overwrite this later
		end
		if (cdb_valid && !flush)
			value_mem[cdb_tag] <= cdb_value;
	end

	assign cdb_offset = cdb_tag - head;

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (tag_width + 1)'(depth))
		else $error("Reorder buffer count %0d exceeds capacity", count);

	// A unit result must land on an allocated entry that is still waiting
	a_cdb_allocated: assert property (@(posedge clk) disable iff (!rst_n || flush)
		cdb_valid |-> ({1'b0, cdb_offset} < count) && !valid[cdb_tag])
		else $error("CDB wrote tag %0d outside the live entries", cdb_tag);

endmodule

//--- src/rob_backend_top.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_backend_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush,
	input  logic                       dispatch,
	input  lc3b_pkg::lc3b_opcode       dispatch_op,
	input  lc3b_pkg::lc3b_reg          dispatch_dest,
	input  logic [`DATA_WIDTH-1:0]     dispatch_a,
	input  logic [`DATA_WIDTH-1:0]     dispatch_b,
	input  logic [`ROB_TAG_WIDTH-1:0]  lookup_tag1,
	input  logic [`ROB_TAG_WIDTH-1:0]  lookup_tag2,
	input  logic [`REG_ADDR_WIDTH-1:0] rf_addr,
	output logic                       dispatch_ready,
	output logic [`ROB_TAG_WIDTH-1:0]  dispatch_tag,
	output logic [`DATA_WIDTH-1:0]     lookup_value1,
	output logic                       lookup_valid1,
	output logic [`DATA_WIDTH-1:0]     lookup_value2,
	output logic                       lookup_valid2,
	output logic                       retire_valid,
	output lc3b_pkg::lc3b_opcode       retire_op,
	output lc3b_pkg::lc3b_reg          retire_dest,
	output logic [`DATA_WIDTH-1:0]     retire_value,
	output logic [`DATA_WIDTH-1:0]     rf_data
);

	logic                      alu_issue;
	logic                      shf_issue;
	logic                      alu_busy;
	logic                      shf_busy;
	logic                      alu_req;
	logic                      shf_req;
	logic                      alu_grant;
	logic                      shf_grant;
	logic [`ROB_TAG_WIDTH-1:0] alu_tag;
	logic [`ROB_TAG_WIDTH-1:0] shf_tag;
	logic [`DATA_WIDTH-1:0]    alu_value;
	logic [`DATA_WIDTH-1:0]    shf_value;
	logic                      cdb_valid;
	logic [`ROB_TAG_WIDTH-1:0] cdb_tag;
	logic [`DATA_WIDTH-1:0]    cdb_value;

	reorder_buffer_data #(
		.data_width(`DATA_WIDTH),
		.tag_width (`ROB_TAG_WIDTH)
	) rob_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (flush),
		.dispatch      (dispatch),
		.dispatch_op   (dispatch_op),
		.dispatch_dest (dispatch_dest),
		.dispatch_a    (dispatch_a),
		.alu_busy      (alu_busy),
		.shf_busy      (shf_busy),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.lookup_tag1   (lookup_tag1),
		.lookup_tag2   (lookup_tag2),
		.dispatch_ready(dispatch_ready),
		.dispatch_tag  (dispatch_tag),
		.alu_issue     (alu_issue),
		.shf_issue     (shf_issue),
		.lookup_value1 (lookup_value1),
		.lookup_valid1 (lookup_valid1),
		.lookup_value2 (lookup_value2),
		.lookup_valid2 (lookup_valid2),
		.retire_valid  (retire_valid),
		.retire_op     (retire_op),
		.retire_dest   (retire_dest),
		.retire_value  (retire_value),
		.empty         (),
		.full          ()
	);

	// Both units read their operands straight from the dispatch port
	alu_unit alu_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.issue    (alu_issue),
		.issue_tag(dispatch_tag),
		.op       (dispatch_op),
		.a        (dispatch_a),
		.b        (dispatch_b),
		.grant    (alu_grant),
		.busy     (alu_busy),
		.req      (alu_req),
		.req_tag  (alu_tag),
		.req_value(alu_value)
	);

	shift_unit shf_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.issue    (shf_issue),
		.issue_tag(dispatch_tag),
		.a        (dispatch_a),
		.b        (dispatch_b),
		.grant    (shf_grant),
		.busy     (shf_busy),
		.req      (shf_req),
		.req_tag  (shf_tag),
		.req_value(shf_value)
	);

	cdb_arbiter arb_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.alu_req  (alu_req),
		.alu_tag  (alu_tag),
		.alu_value(alu_value),
		.shf_req  (shf_req),
		.shf_tag  (shf_tag),
		.shf_value(shf_value),
		.alu_grant(alu_grant),
		.shf_grant(shf_grant),
		.cdb_valid(cdb_valid),
		.cdb_tag  (cdb_tag),
		.cdb_value(cdb_value)
	);

	arch_regfile rf_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.retire_valid(retire_valid),
		.retire_op   (retire_op),
		.retire_dest (retire_dest),
		.retire_value(retire_value),
		.rf_addr     (rf_addr),
		.rf_data     (rf_data)
	);

endmodule

//--- src/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// Tag width of the reorder buffer, which holds 2**ROB_TAG_WIDTH entries
`define ROB_TAG_WIDTH 3

// Width of every result value and operand
`define DATA_WIDTH 16

// Architectural register file
`define REG_COUNT 8
`define REG_ADDR_WIDTH 3 // Index width for REG_COUNT registers

`endif

//--- src/shift_unit.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module shift_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      issue,
	input  logic [`ROB_TAG_WIDTH-1:0] issue_tag,
	input  logic [`DATA_WIDTH-1:0]    a,
	input  logic [`DATA_WIDTH-1:0]    b,
	input  logic                      grant,
	output logic                      busy,
	output logic                      req,
	output logic [`ROB_TAG_WIDTH-1:0] req_tag,
	output logic [`DATA_WIDTH-1:0]    req_value
);
	import lc3b_pkg::*;

	localparam int amt_width = 4; // Shift amount sits in b[3:0]

	logic [amt_width-1:0]   remaining; // Bits still to shift
	logic                   dir_right;
	logic                   arith;
	logic                   stepping;
	logic [`DATA_WIDTH-1:0] shifted;

	assign stepping = busy && !req; // Shifting until the count runs out

	always_comb
	begin
		if (!dir_right)
			shifted = {req_value[`DATA_WIDTH-2:0], 1'b0};
		else if (arith)
			shifted = {req_value[`DATA_WIDTH-1], req_value[`DATA_WIDTH-1:1]};
		else
			shifted = {1'b0, req_value[`DATA_WIDTH-1:1]};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			req <= 1'b0;
			remaining <= '0;
		end
		else if (flush)
		begin
			busy <= 1'b0; // In-flight shift is dropped
			req <= 1'b0;
		end
		else if (issue)
		begin
			busy <= 1'b1;
			req <= (b[amt_width-1:0] == '0); // A zero shift is ready at once
			remaining <= b[amt_width-1:0];
		end
		else if (req && grant)
		begin
			busy <= 1'b0;
			req <= 1'b0;
		end
		else if (stepping)
		begin
			remaining <= remaining - 1'b1;
			if (remaining == amt_width'(1))
				req <= 1'b1; // Last bit goes in at this edge
		end
	end

	// Operand register doubles as the result register
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			req_value <= a;
			req_tag <= issue_tag;
			dir_right <= b[shf_dir_bit];
			arith <= b[shf_arith_bit];
		end
		else if (stepping)
			req_value <= shifted;
	end

	a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !issue)
		else $error("Shifter issued while busy");

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int period_ns = 8 // Full clock period
) (
	output logic clk
);

	// Free-running clock starting low
	initial
	begin
		clk = 1'b0;
		forever
			#(period_ns / 2) clk = ~clk;
	end

endmodule

//--- tests/tb_rob_backend.sv
`timescale 1ns/1ps
`include "rob_macros.svh"

module tb_rob_backend;
	import lc3b_pkg::*;

	localparam int dw = `DATA_WIDTH;
	localparam int tw = `ROB_TAG_WIDTH;
	localparam int depth = 2 ** `ROB_TAG_WIDTH; // Entries in the buffer
	localparam int send_limit = 64;   // Cycles a dispatch may wait for ready
	localparam int drain_limit = 400; // Cycles for the buffer to empty
	localparam int run_limit_ns = 2000000;

	typedef struct packed {
		lc3b_opcode    op;
		lc3b_reg       dest;
		logic [dw-1:0] value;
	} entry_t;

	logic                        clk;
	logic                        rst_n;
	logic                        flush;
	logic                        dispatch;
	lc3b_opcode                  dispatch_op;
	lc3b_reg                     dispatch_dest;
	logic [dw-1:0]               dispatch_a;
	logic [dw-1:0]               dispatch_b;
	logic [tw-1:0]               lookup_tag1;
	logic [tw-1:0]               lookup_tag2;
	logic [`REG_ADDR_WIDTH-1:0]  rf_addr;
	logic                        dispatch_ready;
	logic [tw-1:0]               dispatch_tag;
	logic [dw-1:0]               lookup_value1;
	logic                        lookup_valid1;
	logic [dw-1:0]               lookup_value2;
	logic                        lookup_valid2;
	logic                        retire_valid;
	lc3b_opcode                  retire_op;
	lc3b_reg                     retire_dest;
	logic [dw-1:0]               retire_value;
	logic [dw-1:0]               rf_data;

	entry_t        model_q[$]; // Accepted instructions in program order
	logic [dw-1:0] model_rf [`REG_COUNT];
	logic [tw-1:0] model_tail; // Tag the next accepted dispatch must get
	string         cur_test;
	int            errors = 0;
	int            test_errors_at_start;
	int            tests_run = 0;
	int            tests_failed = 0;
	int            retired;

	tb_clk_gen #(.period_ns(8)) clk_gen_i (.clk(clk));

	rob_backend_top rob_backend_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (flush),
		.dispatch      (dispatch),
		.dispatch_op   (dispatch_op),
		.dispatch_dest (dispatch_dest),
		.dispatch_a    (dispatch_a),
		.dispatch_b    (dispatch_b),
		.lookup_tag1   (lookup_tag1),
		.lookup_tag2   (lookup_tag2),
		.rf_addr       (rf_addr),
		.dispatch_ready(dispatch_ready),
		.dispatch_tag  (dispatch_tag),
		.lookup_value1 (lookup_value1),
		.lookup_valid1 (lookup_valid1),
		.lookup_value2 (lookup_value2),
		.lookup_valid2 (lookup_valid2),
		.retire_valid  (retire_valid),
		.retire_op     (retire_op),
		.retire_dest   (retire_dest),
		.retire_value  (retire_value),
		.rf_data       (rf_data)
	);

	// Result an instruction must retire with, straight from the LC-3b arithmetic
	function automatic logic [dw-1:0] expected_result(lc3b_opcode op, logic [dw-1:0] a,
		logic [dw-1:0] b);
		logic [3:0] amount;
		amount = b[3:0];
		case (op)
			op_add: return a + b;
			op_and: return a & b;
			op_not: return ~a;
			op_shf:
			begin
				if (!b[shf_dir_bit])
					return a << amount;
				else if (b[shf_arith_bit])
					return $unsigned($signed(a) >>> amount); // Sign bit fills from the top
				else
					return a >> amount;
			end
			default: return a; // Ops without a unit carry operand a through
		endcase
	endfunction

	function automatic bit writes_register(lc3b_opcode op);
		return op inside {op_add, op_and, op_not, op_shf, op_lea, op_ldb, op_ldr, op_ldi};
	endfunction

	function automatic lc3b_reg random_reg();
		return lc3b_reg'($urandom_range(0, `REG_COUNT - 1));
	endfunction

	function automatic lc3b_opcode random_alu_op();
		case ($urandom_range(0, 2))
			0: return op_add;
			1: return op_and;
			default: return op_not;
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("mismatch %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
		errors++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors_at_start = errors;
		retired = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors_at_start)
			$display("test %s passed", cur_test);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errors - test_errors_at_start);
		end
	endtask

	// Holds one instruction on the port until the buffer takes it
	task automatic send(input lc3b_opcode op, input lc3b_reg dest, input logic [dw-1:0] a,
		input logic [dw-1:0] b, output logic [tw-1:0] tag);
		int waited;
		@(negedge clk);
		dispatch = 1'b1;
		dispatch_op = op;
		dispatch_dest = dest;
		dispatch_a = a;
		dispatch_b = b;
		waited = 0;
		@(posedge clk);
		while (!dispatch_ready && waited < send_limit)
		begin
			@(posedge clk);
			waited++;
		end
		if (!dispatch_ready)
		begin
			$display("%s: dispatch was not accepted within %0d cycles", cur_test, send_limit);
			errors++;
		end
		tag = dispatch_tag; // Sampled in the accepting cycle
	endtask

	// The stimulus knows how many instructions it meant to leave behind
	task automatic drain(input int expected_retires);
		int waited;
		@(negedge clk);
		dispatch = 1'b0;
		waited = 0;
		while (model_q.size() != 0 && waited < drain_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (model_q.size() != 0)
		begin
			$display("%s: buffer did not drain within %0d cycles", cur_test, drain_limit);
			errors++;
		end
		if (retired != expected_retires)
			report_mismatch("retire count", expected_retires, retired);
	endtask

	// Reference model, tracks acceptance and checks every retire against the oldest entry
	always @(posedge clk)
	begin
		entry_t head;
		entry_t fresh;
		if (rst_n)
		begin
			if (flush)
			begin
				model_q.delete(); // Everything in flight is gone
				model_tail = '0;
			end
			else
			begin
				if (retire_valid)
				begin
					if (model_q.size() == 0)
					begin
						$display("%s: retire seen with nothing outstanding", cur_test);
						errors++;
					end
					else
					begin
						head = model_q.pop_front();
						if (retire_op != head.op)
							report_mismatch("retire op", head.op, retire_op);
						if (retire_dest != head.dest)
							report_mismatch("retire dest", head.dest, retire_dest);
						if (retire_value != head.value)
							report_mismatch("retire value", head.value, retire_value);
						if (writes_register(head.op))
							model_rf[head.dest] = head.value;
						retired++;
					end
				end
				if (dispatch && dispatch_ready)
				begin
					if (dispatch_tag != model_tail)
						report_mismatch("dispatch tag", model_tail, dispatch_tag);
					fresh.op = dispatch_op;
					fresh.dest = dispatch_dest;
					fresh.value = expected_result(dispatch_op, dispatch_a, dispatch_b);
					model_q.push_back(fresh);
					model_tail = model_tail + 1'b1;
				end
			end
		end
	end

	// Stops a hung run
	initial
	begin
		#(run_limit_ns);
		$display("simulation time limit reached before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		logic [tw-1:0] tag;
		logic [tw-1:0] shf_tag;
		logic [tw-1:0] lea_tag;
		logic [dw-1:0] shf_a;
		logic [dw-1:0] shf_b;
		logic [dw-1:0] lea_a;
		int            n_taken;
		bit            full_seen;
		bit            retire_seen;
		int            waited;

		rst_n = 1'b0;
		flush = 1'b0;
		dispatch = 1'b0;
		dispatch_op = op_br;
		dispatch_dest = '0;
		dispatch_a = '0;
		dispatch_b = '0;
		lookup_tag1 = '0;
		lookup_tag2 = '0;
		rf_addr = '0;
		model_tail = '0;
		for (int r = 0; r < `REG_COUNT; r++)
			model_rf[r] = '0;
		void'($urandom(32'h9fdb));
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		@(posedge clk);
		if (!dispatch_ready)
			report_mismatch("dispatch_ready", 1, dispatch_ready);
		if (retire_valid)
			report_mismatch("retire_valid", 0, retire_valid);
		@(negedge clk);
		end_test();

		// Mixed ops at full dispatch rate, any opcode and any shift amount
		start_test("random_stream");
		for (int i = 0; i < 200; i++)
			send(lc3b_opcode'(4'($urandom_range(0, 15))), random_reg(), dw'($urandom()),
				dw'($urandom()), tag);
		drain(200);
		end_test();

		start_test("regfile");
		for (int r = 0; r < `REG_COUNT; r++)
		begin
			@(negedge clk);
			rf_addr = `REG_ADDR_WIDTH'(r);
			@(posedge clk);
			if (rf_data != model_rf[r])
				report_mismatch($sformatf("R%0d", r), model_rf[r], rf_data);
		end
		@(negedge clk);
		end_test();

		// A 15-bit shift sits at the head while the buffer fills up behind it
		start_test("back_pressure");
		send(op_shf, random_reg(), dw'($urandom()), dw'(15), tag);
		n_taken = 1;
		full_seen = 1'b0;
		while (!full_seen && n_taken < 2 * depth)
		begin
			@(negedge clk);
			dispatch = 1'b1;
			dispatch_op = op_lea;
			dispatch_dest = random_reg();
			dispatch_a = dw'($urandom());
			@(posedge clk);
			if (dispatch_ready)
				n_taken++;
			else
				full_seen = 1'b1;
		end
		if (n_taken != depth)
			report_mismatch("accepted before full", depth, n_taken);
		drain(depth);
		end_test();

		start_test("lookup");
		shf_a = dw'($urandom());
		lea_a = dw'($urandom());
		send(op_shf, random_reg(), shf_a, dw'(16'h003c), shf_tag); // Arithmetic right by 12
		send(op_lea, random_reg(), lea_a, dw'($urandom()), lea_tag);
		@(negedge clk);
		dispatch = 1'b0;
		lookup_tag1 = shf_tag;
		lookup_tag2 = lea_tag;
		@(posedge clk);
		if (!lookup_valid2)
			report_mismatch("lea lookup valid", 1, lookup_valid2);
		if (lookup_value2 != lea_a)
			report_mismatch("lea lookup value", lea_a, lookup_value2);
		if (lookup_valid1)
			report_mismatch("shift lookup valid early", 0, lookup_valid1);
		waited = 0;
		while (!lookup_valid1 && waited < send_limit)
		begin
			@(posedge clk);
			waited++;
		end
		if (!lookup_valid1)
		begin
			$display("%s: shift result never became visible on the lookup port", cur_test);
			errors++;
		end
		else if (lookup_value1 != expected_result(op_shf, shf_a, dw'(16'h003c)))
			report_mismatch("shift lookup value", expected_result(op_shf, shf_a,
				dw'(16'h003c)), lookup_value1);
		drain(2);
		end_test();

		// Work behind a long shift is thrown away, then the buffer restarts at tag 0
		start_test("flush");
		send(op_shf, random_reg(), dw'($urandom()), dw'(15), tag);
		send(random_alu_op(), random_reg(), dw'($urandom()), dw'($urandom()), tag);
		send(op_trap, random_reg(), dw'($urandom()), dw'($urandom()), tag);
		@(negedge clk);
		dispatch = 1'b0;
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		retired = 0;
		retire_seen = 1'b0;
		for (int c = 0; c < 40; c++)
		begin
			@(posedge clk);
			if (retire_valid)
				retire_seen = 1'b1;
		end
		if (retire_seen)
		begin
			$display("%s: an instruction retired after the flush", cur_test);
			errors++;
		end
		send(op_lea, random_reg(), dw'($urandom()), dw'($urandom()), tag);
		if (tag != '0)
			report_mismatch("first tag after flush", 0, tag);
		for (int i = 0; i < 20; i++)
			send(lc3b_opcode'(4'($urandom_range(0, 15))), random_reg(), dw'($urandom()),
				dw'($urandom()), tag);
		drain(21);
		end_test();

		// Short shifts followed by ALU ops make both units request in the same cycle
		start_test("arbitration");
		for (int i = 0; i < 40; i++)
		begin
			shf_b = dw'($urandom_range(0, 2));
			shf_b[shf_dir_bit] = 1'($urandom_range(0, 1));
			shf_b[shf_arith_bit] = 1'($urandom_range(0, 1));
			send(op_shf, random_reg(), dw'($urandom()), shf_b, tag);
			send(random_alu_op(), random_reg(), dw'($urandom()), dw'($urandom()), tag);
		end
		drain(80);
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
